//--- src/fbgfx_defs.svh
// framebuffer graphics subsystem
// screen timing, framebuffer geometry and pipeline latencies
`ifndef FBGFX_DEFS_SVH
`define FBGFX_DEFS_SVH

`define CORDW     16   // signed coordinate width

// small test video mode, active region first then blanking
`define H_ACTIVE  160
`define H_TOTAL   200
`define V_ACTIVE  120
`define V_TOTAL   130

// framebuffer geometry and placement on screen
`define FB_WIDTH  64
`define FB_HEIGHT 48
`define FB_SCALE  2
`define FB_OFFX   16
`define FB_OFFY   12
`define FB_PIXELS (`FB_WIDTH * `FB_HEIGHT)
`define FB_ADDRW  $clog2(`FB_PIXELS)

`define CIDXW     4    // colour index bits
`define CHANW     4    // bits per colour channel

`define LAT_ADDR  3    // bitmap_addr pipeline depth
`define LAT_LB    3    // window lead: rd_en reg, linebuffer read, palette reg

`endif

//--- src/disp_pkg.sv
// display types
// coordinates, colour words, palette and background bands
`include "fbgfx_defs.svh"

package disp_pkg;

    typedef logic signed [`CORDW-1:0] coord_t;
    typedef logic [`CIDXW-1:0] cidx_t;

    typedef struct packed {
        logic [`CHANW-1:0] r;
        logic [`CHANW-1:0] g;
        logic [`CHANW-1:0] b;
    } rgb_t;

    // raw view for the transparency compare, rgb view for output
    typedef union packed {
        logic [3*`CHANW-1:0] raw;
        rgb_t rgb;
    } colr_t;

    localparam colr_t PALETTE [16] = '{
        12'h223, 12'h526, 12'hB45, 12'hE85, 12'hFD7, 12'hAE6, 12'h3B6, 12'h276,
        12'h236, 12'h36B, 12'h4AF, 12'h7FF, 12'hFFF, 12'h9AC, 12'h578, 12'h335
    };
    localparam colr_t COLR_TRANS = PALETTE[0];  // index 0 shows background

    typedef struct packed {
        coord_t sy;   // first screen line of band
        colr_t colr;
    } bg_band_t;

    localparam bg_band_t BG_BANDS [4] = '{
        '{sy: 16'sd0,   colr: 12'h000},
        '{sy: 16'sd12,  colr: 12'h239},
        '{sy: 16'sd60,  colr: 12'h26C},
        '{sy: 16'sd108, colr: 12'h260}
    };

endpackage

//--- src/draw_pkg.sv
// drawing types
// rectangle record and the fixed scene
package draw_pkg;
    import disp_pkg::*;

    // corners inclusive, framebuffer coordinates
    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        cidx_t cidx;
    } rect_t;

    localparam int SCENE_LEN = 6;

    // drawn in order, later entries overwrite earlier ones
    localparam rect_t SCENE [SCENE_LEN] = '{
        '{16'sd4,  16'sd4,  16'sd27, 16'sd19, 4'd2},
        '{16'sd20, 16'sd10, 16'sd45, 16'sd30, 4'd5},
        '{16'sd40, 16'sd2,  16'sd79, 16'sd14, 4'd9},   // past right edge
        '{16'sd8,  16'sd30, 16'sd23, 16'sd59, 4'd11},  // past bottom edge
        '{16'sd30, 16'sd24, 16'sd50, 16'sd40, 4'd0},   // transparent hole
        '{-16'sd5, 16'sd40, 16'sd10, 16'sd44, 4'd14}   // past left edge
    };

endpackage

//--- src/display_timing.sv
// display timing generator
// raster counters with registered de, frame and line strobes
`include "fbgfx_defs.svh"

module display_timing import disp_pkg::*; (
    input  logic   clk_sys,
    input  logic   rst_sys,
    output coord_t sx,
    output coord_t sy,
    output logic   de,
    output logic   frame,
    output logic   line
);

    coord_t sx_nxt, sy_nxt;  // position on the next cycle

    always_comb begin
        sx_nxt = sx + 16'sd1;
        sy_nxt = sy;
        if (sx == `H_TOTAL - 1) begin  // end of line
            sx_nxt = '0;
            sy_nxt = (sy == `V_TOTAL - 1) ? '0 : sy + 16'sd1;
        end
    end

    // strobes decoded from next position so they line up with sx, sy
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            sx    <= '0;
            sy    <= '0;
            de    <= 1'b1;  // 0,0 is active
            frame <= 1'b1;
            line  <= 1'b1;
        end else begin
            sx    <= sx_nxt;
            sy    <= sy_nxt;
            de    <= (sx_nxt < `H_ACTIVE) && (sy_nxt < `V_ACTIVE);
            frame <= (sx_nxt == 0) && (sy_nxt == 0);
            line  <= (sx_nxt == 0);
        end
    end

endmodule

//--- src/frame_ctrl.sv
// frame sequencer
// draw start, write delay line, framebuffer read and linebuffer control
`include "fbgfx_defs.svh"

module frame_ctrl import disp_pkg::*; (
    input  logic                 clk_sys,
    input  logic                 rst_sys,
    input  logic                 frame,
    input  logic                 line,
    input  coord_t               sy,
    input  logic                 drawing,
    input  cidx_t                dcidx,
    input  logic                 clip,
    output logic                 fb_we,
    output cidx_t                fb_wdata,
    output logic                 draw_start,
    output logic [`FB_ADDRW-1:0] fb_raddr,
    output logic                 lb_wr_en,
    output logic                 lb_line,
    output logic                 lb_rd_en,
    input  coord_t               sx
);

    logic [1:0] frame_cnt;                  // saturates at 2
    logic [`LAT_ADDR-1:0] we_sr;            // drawing delayed to match waddr
    cidx_t cidx_sr [`LAT_ADDR];
    logic [$clog2(`FB_SCALE):0] row_cnt;    // display line within scaled row
    logic [$clog2(`FB_SCALE):0] row_nxt;
    logic fill_row;                         // this line fills the linebuffer
    logic [$clog2(`FB_WIDTH):0] lbx;        // pixels fetched this line

    // draw once, on the second frame after reset
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            frame_cnt  <= '0;
            draw_start <= 1'b0;
        end else begin
            draw_start <= frame && (frame_cnt == 2'd1);
            if (frame && frame_cnt != 2'd2) frame_cnt <= frame_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) we_sr <= '0;
        else we_sr <= {we_sr[`LAT_ADDR-2:0], drawing};
        cidx_sr[0] <= dcidx;  // colour is payload
        for (int i = 1; i < `LAT_ADDR; i++) cidx_sr[i] <= cidx_sr[i-1];
    end

    always_comb begin
        fb_we    = we_sr[`LAT_ADDR-1] && !clip;  // drop clipped pixels
        fb_wdata = cidx_sr[`LAT_ADDR-1];
    end

    // row repeat, restarts on the line before the first fb row shows
    always_comb begin
        if (sy == `FB_OFFY - 1) row_nxt = '0;
        else if (row_cnt == `FB_SCALE - 1) row_nxt = '0;
        else row_nxt = row_cnt + 1'b1;
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            row_cnt  <= '0;
            fill_row <= 1'b0;
            lb_line  <= 1'b0;
        end else begin
            lb_line <= line && fill_row;  // swap after a filled line
            if (line) begin
                row_cnt  <= row_nxt;
                fill_row <= (sy >= `FB_OFFY - 1)
                    && (sy < `FB_OFFY - 1 + `FB_HEIGHT * `FB_SCALE) && (row_nxt == 0);
            end
        end
    end

    assign lb_wr_en = fill_row && (lbx < `FB_WIDTH);

    // sequential fb read, one row per fill line
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            lbx      <= '0;
            fb_raddr <= '0;
        end else begin
            if (line) lbx <= '0;
            else if (lb_wr_en) lbx <= lbx + 1'b1;
            if (frame) fb_raddr <= '0;
            else if (lb_wr_en) fb_raddr <= fb_raddr + 1'b1;
        end
    end

    // output window, leads painted area by LAT_LB
    always_ff @(posedge clk_sys) begin
        if (rst_sys) lb_rd_en <= 1'b0;
        else lb_rd_en <= (sy >= `FB_OFFY) && (sy < `FB_OFFY + `FB_HEIGHT * `FB_SCALE)
            && (sx >= `FB_OFFX - `LAT_LB)
            && (sx < `FB_OFFX + `FB_WIDTH * `FB_SCALE - `LAT_LB);
    end

endmodule

//--- src/rect_render.sv
// filled rectangle renderer
// walks the scene and emits one draw pixel per cycle
`include "fbgfx_defs.svh"

module rect_render import disp_pkg::*, draw_pkg::*; (
    input  logic   clk_sys,
    input  logic   rst_sys,
    input  logic   draw_start,
    output coord_t drx,
    output coord_t dry,
    output cidx_t  dcidx,
    output logic   drawing,
    output logic   done
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_INIT = 2'd1;  // load corner of next rect
    localparam logic [1:0] S_DRAW = 2'd2;
    localparam logic [1:0] S_DONE = 2'd3;

    logic [1:0] state;
    logic [$clog2(SCENE_LEN)-1:0] idx;  // current rectangle
    rect_t rect;

    assign rect = SCENE[idx];

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state <= S_IDLE;
            idx   <= '0;
        end else if (draw_start) begin  // restart from any state
            state <= S_INIT;
            idx   <= '0;
        end else begin
            case (state)
                S_INIT: begin
                    drx   <= rect.x0;
                    dry   <= rect.y0;
                    state <= S_DRAW;
                end
                S_DRAW: begin
                    if (drx != rect.x1) begin
                        drx <= drx + 16'sd1;
                    end else if (dry != rect.y1) begin  // next row
                        drx <= rect.x0;
                        dry <= dry + 16'sd1;
                    end else if (idx == SCENE_LEN - 1) begin
                        state <= S_DONE;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= S_INIT;
                    end
                end
                S_DONE:  state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_comb begin
        drawing = (state == S_DRAW);
        done    = (state == S_DONE);  // one cycle
        dcidx   = rect.cidx;
    end

endmodule

//--- src/bitmap_addr.sv
// bitmap address pipeline
// clips a draw coordinate, then y * width + x over three stages
`include "fbgfx_defs.svh"

module bitmap_addr import disp_pkg::*; (
    input  logic                 clk_sys,
    input  coord_t               x,
    input  coord_t               y,
    output logic [`FB_ADDRW-1:0] waddr,
    output logic                 clip
);

    coord_t x1, y1;
    logic clip1, clip2;
    logic [`FB_ADDRW-1:0] x2;
    logic [`FB_ADDRW-1:0] row_base;  // y * width

    always_ff @(posedge clk_sys) begin
        // stage 1, bounds check against bitmap
        x1    <= x;
        y1    <= y;
        clip1 <= (x < 0) || (x >= `FB_WIDTH) || (y < 0) || (y >= `FB_HEIGHT);

        // stage 2, row multiply
        row_base <= y1[`FB_ADDRW-1:0] * `FB_ADDRW'(`FB_WIDTH);
        x2       <= x1[`FB_ADDRW-1:0];
        clip2    <= clip1;

        // stage 3
        waddr <= row_base + x2;
        clip  <= clip2;
    end

endmodule

//--- src/fb_ram.sv
// framebuffer memory
// simple dual port, registered read, starts transparent
`include "fbgfx_defs.svh"

module fb_ram import disp_pkg::*; (
    input  logic                 clk_sys,
    input  logic                 we,
    input  logic [`FB_ADDRW-1:0] waddr,
    input  logic [`FB_ADDRW-1:0] raddr,
    input  cidx_t                wdata,
    output cidx_t                rdata
);

    cidx_t mem [`FB_PIXELS] = '{default: '0};  // index 0 everywhere

    always_ff @(posedge clk_sys) begin
        if (we) mem[waddr] <= wdata;
        rdata <= mem[raddr];
    end

endmodule

//--- src/linebuffer.sv
// double-banked linebuffer
// fills one row bank while the other is read out with pixel repeat
`include "fbgfx_defs.svh"

module linebuffer import disp_pkg::*; (
    input  logic  clk_sys,
    input  logic  rst_sys,
    input  logic  lb_line,
    input  logic  wr_en,
    input  logic  rd_en,
    input  cidx_t wdata,
    output cidx_t rdata
);

    cidx_t bank [2][`FB_WIDTH];
    logic wr_sel;                        // bank being filled
    logic wr_en_d;                       // matches fb_ram read latency
    logic [$clog2(`FB_WIDTH)-1:0] widx;
    logic [$clog2(`FB_WIDTH)-1:0] ridx;
    logic [$clog2(`FB_SCALE):0] rep;     // horizontal repeat count

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            wr_sel  <= 1'b0;
            wr_en_d <= 1'b0;
            widx    <= '0;
            ridx    <= '0;
            rep     <= '0;
        end else begin
            wr_en_d <= wr_en;
            if (lb_line) wr_sel <= !wr_sel;
            widx <= wr_en_d ? widx + 1'b1 : '0;  // rewinds between fills
            if (lb_line || !rd_en) begin
                ridx <= '0;
                rep  <= '0;
            end else if (rep == `FB_SCALE - 1) begin
                rep  <= '0;
                ridx <= ridx + 1'b1;
            end else begin
                rep <= rep + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (wr_en_d) bank[wr_sel][widx] <= wdata;
        if (rd_en) rdata <= bank[!wr_sel][ridx];  // holds outside window
    end

endmodule

//--- src/pixel_paint.sv
// pixel painter
// palette lookup, background bands, transparency and output registers
`include "fbgfx_defs.svh"

module pixel_paint import disp_pkg::*; (
    input  logic       clk_sys,
    input  logic       rst_sys,
    input  logic       line,
    input  coord_t     sx,
    input  coord_t     sy,
    input  logic       de,
    input  logic       frame,
    input  cidx_t      cidx,
    output coord_t     sdl_sx,
    output coord_t     sdl_sy,
    output logic       sdl_de,
    output logic       sdl_frame,
    output logic [7:0] sdl_r,
    output logic [7:0] sdl_g,
    output logic [7:0] sdl_b
);

    colr_t pal_colr;    // registered lookup
    colr_t bg_reg;      // band held since last line start
    colr_t bg_colr;     // band of the current line
    colr_t paint_colr;
    logic  paint_area;

    // a new band shows from column 0 of its first line
    always_comb begin
        bg_colr = bg_reg;
        for (int i = 0; i < 4; i++) begin
            if (line && sy == BG_BANDS[i].sy) bg_colr = BG_BANDS[i].colr;
        end
    end

    always_ff @(posedge clk_sys) begin
        pal_colr <= PALETTE[cidx];
        bg_reg   <= bg_colr;
    end

    always_comb begin
        paint_area = (sx >= `FB_OFFX) && (sx < `FB_OFFX + `FB_WIDTH * `FB_SCALE)
            && (sy >= `FB_OFFY) && (sy < `FB_OFFY + `FB_HEIGHT * `FB_SCALE);
        if (!de) paint_colr = '0;                               // blanking is black
        else if (!paint_area) paint_colr = bg_colr;
        else if (pal_colr.raw == COLR_TRANS.raw) paint_colr = bg_colr;
        else paint_colr = pal_colr;
    end

    // sdl outputs, channels doubled to 8 bits
    always_ff @(posedge clk_sys) begin
        sdl_sx <= sx;
        sdl_sy <= sy;
        if (rst_sys) begin
            sdl_de    <= 1'b0;
            sdl_frame <= 1'b0;
            sdl_r     <= '0;
            sdl_g     <= '0;
            sdl_b     <= '0;
        end else begin
            sdl_de    <= de;
            sdl_frame <= frame;
            sdl_r     <= {2{paint_colr.rgb.r}};
            sdl_g     <= {2{paint_colr.rgb.g}};
            sdl_b     <= {2{paint_colr.rgb.b}};
        end
    end

endmodule

//--- src/fbgfx_top.sv
// framebuffer graphics top level
// timing, renderer, framebuffer, linebuffer and painter wired together
`include "fbgfx_defs.svh"

module fbgfx_top import disp_pkg::*; (
    input  logic       clk_sys,
    input  logic       rst_sys,
    output coord_t     sdl_sx,
    output coord_t     sdl_sy,
    output logic       sdl_de,
    output logic       sdl_frame,
    output logic [7:0] sdl_r,
    output logic [7:0] sdl_g,
    output logic [7:0] sdl_b,
    output logic       draw_done
);

    coord_t sx, sy;
    logic   de, frame, line;

    coord_t drx, dry;     // draw coordinate
    cidx_t  dcidx;
    logic   drawing, draw_start;

    logic [`FB_ADDRW-1:0] fb_waddr, fb_raddr;
    logic  fb_we, clip;
    cidx_t fb_wdata, fb_rdata;

    logic  lb_wr_en, lb_line, lb_rd_en;
    cidx_t lb_cidx;

    display_timing u_timing (
        .clk_sys, .rst_sys, .sx, .sy, .de, .frame, .line
    );

    frame_ctrl u_ctrl (
        .clk_sys, .rst_sys, .frame, .line, .sy,
        .drawing, .dcidx, .clip,
        .fb_we, .fb_wdata, .draw_start, .fb_raddr,
        .lb_wr_en, .lb_line, .lb_rd_en, .sx
    );

    rect_render u_render (
        .clk_sys, .rst_sys, .draw_start,
        .drx, .dry, .dcidx, .drawing,
        .done (draw_done)
    );

    bitmap_addr u_addr (
        .clk_sys,
        .x     (drx),
        .y     (dry),
        .waddr (fb_waddr),
        .clip
    );

    fb_ram u_fb (
        .clk_sys,
        .we    (fb_we),
        .waddr (fb_waddr),
        .raddr (fb_raddr),
        .wdata (fb_wdata),
        .rdata (fb_rdata)
    );

    linebuffer u_lb (
        .clk_sys, .rst_sys, .lb_line,
        .wr_en (lb_wr_en),
        .rd_en (lb_rd_en),
        .wdata (fb_rdata),
        .rdata (lb_cidx)
    );

    pixel_paint u_paint (
        .clk_sys, .rst_sys, .line, .sx, .sy, .de, .frame,
        .cidx (lb_cidx),
        .sdl_sx, .sdl_sy, .sdl_de, .sdl_frame, .sdl_r, .sdl_g, .sdl_b
    );

endmodule

//--- testbench/tb_fbgfx.sv
// testbench for the framebuffer graphics top level
// reference framebuffer from the scene, output checks by concurrent assertions
`include "fbgfx_defs.svh"

module tb_fbgfx import disp_pkg::*, draw_pkg::*; ();

    logic       clk_sys = 1'b0;
    logic       rst_sys;
    coord_t     sdl_sx, sdl_sy;
    logic       sdl_de, sdl_frame;
    logic [7:0] sdl_r, sdl_g, sdl_b;
    logic       draw_done;

    cidx_t ref_fb [`FB_HEIGHT][`FB_WIDTH];  // scene applied in order, clipped

    int     cyc_run = 0;          // cycles since reset released
    int     frame_idx = -1;       // 0 is the first frame out of reset
    int     done_cnt = 0;
    logic   rst_d = 1'b0;
    logic   done_d = 1'b0;
    coord_t prev_sx, prev_sy;
    coord_t exp_sx, exp_sy;       // next raster position

    colr_t       exp_colr;
    logic [23:0] exp_rgb, got_rgb;
    logic        in_paint, colour_on;

    int          spot_x [8];      // random coordinates checked in frame 3
    int          spot_y [8];
    logic [23:0] spot_rgb [8];
    logic [7:0]  spot_seen = '0;
    logic        spot_hit;
    int          spot_sel;
    logic [23:0] spot_exp;

    fbgfx_top u_dut (
        .clk_sys, .rst_sys, .sdl_sx, .sdl_sy, .sdl_de, .sdl_frame,
        .sdl_r, .sdl_g, .sdl_b, .draw_done
    );

    always #5 clk_sys = ~clk_sys;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        fail_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h (sdl_sx %0d, sdl_sy %0d)",
            name, got, exp, sdl_sx, sdl_sy));
    endtask

    task automatic build_reference();
        rect_t r;
        for (int y = 0; y < `FB_HEIGHT; y++) begin
            for (int x = 0; x < `FB_WIDTH; x++) ref_fb[y][x] = '0;  // transparent
        end
        for (int n = 0; n < SCENE_LEN; n++) begin
            r = SCENE[n];
            for (int y = r.y0; y <= r.y1; y++) begin
                for (int x = r.x0; x <= r.x1; x++) begin
                    if (x >= 0 && x < `FB_WIDTH && y >= 0 && y < `FB_HEIGHT)
                        ref_fb[y][x] = r.cidx;  // later rects win
                end
            end
        end
    endtask

    function automatic logic painted(input int x, input int y);
        return (x >= `FB_OFFX) && (x < `FB_OFFX + `FB_WIDTH * `FB_SCALE)
            && (y >= `FB_OFFY) && (y < `FB_OFFY + `FB_HEIGHT * `FB_SCALE);
    endfunction

    function automatic colr_t band_colour(input int y);
        colr_t c;
        c = BG_BANDS[0].colr;
        for (int i = 1; i < 4; i++) begin
            if (y >= BG_BANDS[i].sy) c = BG_BANDS[i].colr;  // last band started
        end
        return c;
    endfunction

    function automatic colr_t expected_colour(input int x, input int y);
        cidx_t idx;
        idx = '0;
        if (painted(x, y))
            idx = ref_fb[(y - `FB_OFFY) / `FB_SCALE][(x - `FB_OFFX) / `FB_SCALE];
        if (idx != 0) return PALETTE[idx];
        return band_colour(y);  // transparent or border
    endfunction

    function automatic logic [23:0] to_rgb(input colr_t c);
        return {{2{c.rgb.r}}, {2{c.rgb.g}}, {2{c.rgb.b}}};  // 4 to 8 bits
    endfunction

    always_comb begin
        if (prev_sx == `H_TOTAL - 1) begin
            exp_sx = '0;
            exp_sy = (prev_sy == `V_TOTAL - 1) ? '0 : prev_sy + 16'sd1;
        end else begin
            exp_sx = prev_sx + 16'sd1;
            exp_sy = prev_sy;
        end
        in_paint  = painted(sdl_sx, sdl_sy);
        exp_colr  = expected_colour(sdl_sx, sdl_sy);
        exp_rgb   = to_rgb(exp_colr);
        got_rgb   = {sdl_r, sdl_g, sdl_b};
        // fb settles after the draw in frame 1, border bands from frame 0
        colour_on = sdl_de && (cyc_run >= 2) && (in_paint ? frame_idx >= 3 : frame_idx >= 0);
    end

    always_comb begin
        spot_hit = 1'b0;
        spot_sel = 0;
        spot_exp = '0;
        for (int i = 0; i < 8; i++) begin
            if (frame_idx == 3 && sdl_sx == spot_x[i] && sdl_sy == spot_y[i]) begin
                spot_hit = 1'b1;
                spot_sel = i;
                spot_exp = spot_rgb[i];
            end
        end
    end

    // tb state, registered like the DUT outputs
    always @(posedge clk_sys) begin
        rst_d   <= rst_sys;
        done_d  <= draw_done;
        prev_sx <= sdl_sx;
        prev_sy <= sdl_sy;
        if (rst_sys) cyc_run <= 0;
        else cyc_run <= cyc_run + 1;
        if (sdl_frame) frame_idx <= frame_idx + 1;
        if (draw_done) done_cnt <= done_cnt + 1;
        if (spot_hit) spot_seen[spot_sel] <= 1'b1;
    end

    a_sx: assert property (@(posedge clk_sys) (cyc_run >= 2) |-> sdl_sx == exp_sx)
        else report_value("sdl_sx", sdl_sx, exp_sx);
    a_sy: assert property (@(posedge clk_sys) (cyc_run >= 2) |-> sdl_sy == exp_sy)
        else report_value("sdl_sy", sdl_sy, exp_sy);
    a_frame: assert property (@(posedge clk_sys)
        (cyc_run >= 1) |-> sdl_frame == (sdl_sx == 0 && sdl_sy == 0))
        else report_value("sdl_frame", sdl_frame, sdl_sx == 0 && sdl_sy == 0);
    a_de: assert property (@(posedge clk_sys)
        (cyc_run >= 1) |-> sdl_de == (sdl_sx < `H_ACTIVE && sdl_sy < `V_ACTIVE))
        else report_value("sdl_de", sdl_de, sdl_sx < `H_ACTIVE && sdl_sy < `V_ACTIVE);
    a_rst_de: assert property (@(posedge clk_sys) rst_d |-> !sdl_de)
        else report_value("sdl_de", sdl_de, 0);
    a_rst_done: assert property (@(posedge clk_sys) rst_d |-> !draw_done)
        else report_value("draw_done", draw_done, 0);
    a_blank: assert property (@(posedge clk_sys)
        ((rst_d || cyc_run >= 1) && !sdl_de) |-> got_rgb == '0)
        else report_value("{sdl_r, sdl_g, sdl_b}", got_rgb, 0);
    a_red: assert property (@(posedge clk_sys) colour_on |-> sdl_r == exp_rgb[23:16])
        else report_value("sdl_r", sdl_r, exp_rgb[23:16]);
    a_green: assert property (@(posedge clk_sys) colour_on |-> sdl_g == exp_rgb[15:8])
        else report_value("sdl_g", sdl_g, exp_rgb[15:8]);
    a_blue: assert property (@(posedge clk_sys) colour_on |-> sdl_b == exp_rgb[7:0])
        else report_value("sdl_b", sdl_b, exp_rgb[7:0]);
    a_spot: assert property (@(posedge clk_sys) spot_hit |-> got_rgb == spot_exp)
        else report_value("{sdl_r, sdl_g, sdl_b}", got_rgb, spot_exp);
    a_done_frame: assert property (@(posedge clk_sys) draw_done |-> frame_idx == 1)
        else fail_run("draw_done pulsed outside the first drawn frame");
    a_done_pulse: assert property (@(posedge clk_sys) draw_done |-> !done_d)
        else fail_run("draw_done stayed high for more than one cycle");

    initial begin
        rst_sys = 1'b1;
        void'($urandom(24));
        build_reference();
        for (int i = 0; i < 8; i++) begin
            spot_x[i]   = `FB_OFFX + ($urandom % (`FB_WIDTH * `FB_SCALE));
            spot_y[i]   = `FB_OFFY + ($urandom % (`FB_HEIGHT * `FB_SCALE));
            spot_rgb[i] = to_rgb(expected_colour(spot_x[i], spot_y[i]));
        end
        repeat (5) @(posedge clk_sys);
        rst_sys <= 1'b0;
        while (frame_idx < 4) @(posedge clk_sys);  // frames 0 to 3 shown
        if (done_cnt == 1 && spot_seen == 8'hFF) begin
            $display("SIMULATION PASSED");
            $finish;
        end else if (done_cnt != 1) begin
            report_value("draw_done pulse count", done_cnt, 1);
        end else begin
            fail_run("not every spot check coordinate was reached in frame 3");
        end
    end

    // watchdog, one frame of margin over reset plus four frames
    initial begin
        repeat (5 * `H_TOTAL * `V_TOTAL) @(posedge clk_sys);
        fail_run("watchdog timeout, the run never reached frame 4");
    end

endmodule

//--- fbgfx.f
+incdir+src
src/disp_pkg.sv
src/draw_pkg.sv
src/display_timing.sv
src/frame_ctrl.sv
src/rect_render.sv
src/bitmap_addr.sv
src/fb_ram.sv
src/linebuffer.sv
src/pixel_paint.sv
src/fbgfx_top.sv
testbench/tb_fbgfx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the fbgfx testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f fbgfx.f --top-module tb_fbgfx

output=$(./obj_dir/Vtb_fbgfx 2>&1) || true
echo "$output"

if grep -q "SIMULATION PASSED" <<< "$output"; then
    exit 0
fi
exit 1
